/* tb.f */
rtl/stk_pkg.sv
rtl/stk_cmd_if.sv
rtl/stk_arb.sv
rtl/stk_pipe_al.sv
rtl/stk_pipe_ex.sv
rtl/stk_top.sv
test/stk_sva.sv
test/tb_stk.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the stack subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_stk -o tb_stk
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/tb_stk
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

echo "Simulation exited with status 0"
exit 0

/* test/tb_stk.sv */
module tb_stk;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int DATA_W  = 32;
  localparam int DEPTH   = 8;
  localparam int NE      = stk_pkg::ENGS_N;
  // Directed commands, then random ones
  localparam int DIR_N   = 2 * (DEPTH + 1) + 9;
  localparam int RAND_N  = 200;
  // Cycle budget for the whole run
  localparam int CYC_LIM = 20 + 4 * (DIR_N + RAND_N);

  logic              clk;
  logic              i_reset;
  // Driven command ports
  logic              req_vld [NE];
  stk_pkg::opcode_t  req_op  [NE];
  logic [DATA_W-1:0] req_dat [NE];
  wire  [NE-1:0]     ack;
  logic [NE-1:0]     rsp_vld;
  logic [DATA_W-1:0] rsp_dat;
  stk_pkg::status_t  rsp_st;

  // Requester state, held until acked
  logic              pend     [NE];
  stk_pkg::opcode_t  pend_op  [NE];
  logic [DATA_W-1:0] pend_dat [NE];

  // Reference stacks
  logic [DATA_W-1:0] mdl_mem [NE][DEPTH];
  int                mdl_ptr [NE];
  int                last_win;
  int                sweep_left;
  int                seed;
  int                cyc_n;
  int                issued;

  // Expected responses, three cycles deep
  logic [NE-1:0]     exp_vld_q [$];
  logic [DATA_W-1:0] exp_dat_q [$];
  stk_pkg::status_t  exp_st_q  [$];

  stk_top #(.DATA_W(DATA_W), .DEPTH(DEPTH)) dut0 (
    .clk           (clk),
    .i_reset       (i_reset),
    .i_cmd0_vld    (req_vld[0]),
    .i_cmd0_opcode (req_op[0]),
    .i_cmd0_dat    (req_dat[0]),
    .o_cmd0_ack    (ack[0]),
    .i_cmd1_vld    (req_vld[1]),
    .i_cmd1_opcode (req_op[1]),
    .i_cmd1_dat    (req_dat[1]),
    .o_cmd1_ack    (ack[1]),
    .i_cmd2_vld    (req_vld[2]),
    .i_cmd2_opcode (req_op[2]),
    .i_cmd2_dat    (req_dat[2]),
    .o_cmd2_ack    (ack[2]),
    .i_cmd3_vld    (req_vld[3]),
    .i_cmd3_opcode (req_op[3]),
    .i_cmd3_dat    (req_dat[3]),
    .o_cmd3_ack    (ack[3]),
    .o_rsp_vld     (rsp_vld),
    .o_rsp_dat     (rsp_dat),
    .o_rsp_status  (rsp_st)
  );

  bind stk_top stk_sva u_sva (
    .clk       (clk),
    .i_reset   (i_reset),
    .i_ack     (cmd_ack),
    .i_busy    (busy),
    .i_rsp_vld (o_rsp_vld)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Finished with errors");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_vld(input string name, input logic [NE-1:0] got, input logic [NE-1:0] exp);
    if (got !== exp) fail_run($sformatf("ERR %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_dat(input string name, input logic [DATA_W-1:0] got,
                           input logic [DATA_W-1:0] exp);
    if (got !== exp) fail_run($sformatf("ERR %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_status(input string name, input stk_pkg::status_t got,
                              input stk_pkg::status_t exp);
    if (got !== exp) fail_run($sformatf("ERR %s got %h expected %h", name, got, exp));
  endtask

  // Cycle limit, counted from time zero
  initial begin
    cyc_n = 0;
    forever begin
      @(posedge clk);
      cyc_n++;
      if (cyc_n >= CYC_LIM) fail_run($sformatf("Timeout, run still going after %0d cycles", cyc_n));
    end
  end

  // Round robin, first requester after the last winner
  function automatic int predict_grant();
    int idx;
    for (int i = 1; i <= NE; i++) begin
      idx = (last_win + i) % NE;
      if (req_vld[idx]) return idx;
    end
    return -1;
  endfunction

  // Mostly push and pop, now and then clear or reserved
  function automatic stk_pkg::opcode_t rand_op();
    int r;
    r = $random(seed) & 15;
    if (r < 7) return stk_pkg::OP_PUSH;
    if (r < 13) return stk_pkg::OP_POP;
    if (r == 13) return stk_pkg::OP_CLEAR;
    return stk_pkg::OP_RSVD;
  endfunction

  function automatic logic any_pend();
    for (int p = 0; p < NE; p++) begin
      if (pend[p]) return 1'b1;
    end
    return 1'b0;
  endfunction

  // Apply an acked command to the model stack of its engine
  task automatic apply_cmd(input int w, output logic [DATA_W-1:0] d, output stk_pkg::status_t st);
    d  = '0;
    st = stk_pkg::ST_OKAY;
    case (pend_op[w])
      stk_pkg::OP_PUSH: begin
        // Push echoes its word, even when full
        d = pend_dat[w];
        if (mdl_ptr[w] == DEPTH) begin
          st = stk_pkg::ST_FULL;
        end else begin
          mdl_mem[w][mdl_ptr[w]] = pend_dat[w];
          mdl_ptr[w]++;
        end
      end
      stk_pkg::OP_POP: begin
        if (mdl_ptr[w] == 0) begin
          st = stk_pkg::ST_EMPTY;
        end else begin
          mdl_ptr[w]--;
          d = mdl_mem[w][mdl_ptr[w]];
        end
      end
      stk_pkg::OP_CLEAR: mdl_ptr[w] = 0;
      default: st = stk_pkg::ST_BADOP;
    endcase
  endtask

  // Drive, check at the falling edge, return 1 ns after the next rise
  task automatic run_cycle();
    int                w;
    logic [NE-1:0]     exp_ack;
    logic [NE-1:0]     e_vld;
    logic [DATA_W-1:0] e_dat;
    stk_pkg::status_t  e_st;
    for (int p = 0; p < NE; p++) begin
      req_vld[p] = pend[p];
      req_op[p]  = pend_op[p];
      req_dat[p] = pend_dat[p];
    end
    @(negedge clk);
    // No grant while the pointer table is swept
    w = (sweep_left > 0) ? -1 : predict_grant();
    if (sweep_left > 0) sweep_left--;
    exp_ack = '0;
    e_vld   = '0;
    e_dat   = '0;
    e_st    = stk_pkg::ST_OKAY;
    if (w >= 0) begin
      exp_ack[w] = 1'b1;
      e_vld[w]   = 1'b1;
      apply_cmd(w, e_dat, e_st);
      last_win = w;
      pend[w]  = 1'b0;
    end
    check_vld("o_cmd_ack", ack, exp_ack);
    // Response of the command acked three cycles ago
    check_vld("o_rsp_vld", rsp_vld, exp_vld_q[0]);
    if (exp_vld_q[0] != '0) begin
      check_dat("o_rsp_dat", rsp_dat, exp_dat_q[0]);
      check_status("o_rsp_status", rsp_st, exp_st_q[0]);
    end
    void'(exp_vld_q.pop_front());
    void'(exp_dat_q.pop_front());
    void'(exp_st_q.pop_front());
    exp_vld_q.push_back(e_vld);
    exp_dat_q.push_back(e_dat);
    exp_st_q.push_back(e_st);
    @(posedge clk);
    #1;
  endtask

  task automatic idle(input int n);
    repeat (n) run_cycle();
  endtask

  // Lone request, the ack compare expects it granted in its first cycle
  task automatic issue(input int port, input stk_pkg::opcode_t op, input logic [DATA_W-1:0] d);
    pend[port]     = 1'b1;
    pend_op[port]  = op;
    pend_dat[port] = d;
    run_cycle();
  endtask

  initial begin
    seed       = 32'hce46;
    last_win   = NE - 1;
    sweep_left = 0;
    issued     = 0;
    i_reset    = 1'b1;
    for (int p = 0; p < NE; p++) begin
      pend[p]     = 1'b0;
      pend_op[p]  = stk_pkg::OP_PUSH;
      pend_dat[p] = '0;
      req_vld[p]  = 1'b0;
      req_op[p]   = stk_pkg::OP_PUSH;
      req_dat[p]  = '0;
      mdl_ptr[p]  = 0;
    end
    repeat (3) begin
      exp_vld_q.push_back('0);
      exp_dat_q.push_back('0);
      exp_st_q.push_back(stk_pkg::ST_OKAY);
    end
    repeat (8) @(posedge clk);
    #1;
    i_reset    = 1'b0;
    sweep_left = NE;
    // Request held through the sweep, acked right after it
    pend[2]     = 1'b1;
    pend_op[2]  = stk_pkg::OP_PUSH;
    pend_dat[2] = $random(seed);
    idle(NE + 1);
    idle(4);
    // Engine 1 past full, then past empty
    repeat (DEPTH + 1) issue(1, stk_pkg::OP_PUSH, $random(seed));
    repeat (DEPTH + 1) issue(1, stk_pkg::OP_POP, '0);
    // Pop right behind a push
    issue(3, stk_pkg::OP_PUSH, $random(seed));
    issue(3, stk_pkg::OP_POP, '0);
    // Clear, then pop an empty stack
    issue(0, stk_pkg::OP_PUSH, $random(seed));
    issue(0, stk_pkg::OP_PUSH, $random(seed));
    issue(0, stk_pkg::OP_CLEAR, '0);
    issue(0, stk_pkg::OP_POP, '0);
    // Reserved code leaves the stack alone
    issue(2, stk_pkg::OP_RSVD, $random(seed));
    issue(2, stk_pkg::OP_POP, '0);
    idle(4);
    // Random traffic on all four ports
    while (issued < RAND_N || any_pend()) begin
      for (int p = 0; p < NE; p++) begin
        if (!pend[p] && issued < RAND_N && ($random(seed) & 3) != 0) begin
          pend[p]     = 1'b1;
          pend_op[p]  = rand_op();
          pend_dat[p] = $random(seed);
          issued++;
        end
      end
      run_cycle();
    end
    idle(4);
    $display("Finished with no errors");
    $finish;
  end

endmodule : tb_stk

/* test/stk_sva.sv */
module stk_sva (
  input logic                       clk,
  input logic                       i_reset,
  input logic [stk_pkg::ENGS_N-1:0] i_ack,
  input logic                       i_busy,
  input logic [stk_pkg::ENGS_N-1:0] i_rsp_vld
);
  timeunit 1ns;
  timeprecision 100ps;

  // One port admitted per cycle at most
  ack_onehot: assert property (@(posedge clk) disable iff (i_reset) $onehot0(i_ack))
    else $error("more than one command port acked in one cycle");

  // Pointer table sweep blocks admission
  ack_busy: assert property (@(posedge clk) disable iff (i_reset) i_busy |-> (i_ack == '0))
    else $error("command acked during the init sweep");

  // One engine answered per cycle
  rsp_onehot: assert property (@(posedge clk) disable iff (i_reset) $onehot0(i_rsp_vld))
    else $error("response valid on more than one engine");

endmodule : stk_sva

/* rtl/stk_top.sv */
module stk_top #(
  parameter int DATA_W = 32,
  parameter int DEPTH  = 8
) (
  input  logic                          clk,
  input  logic                          i_reset,
  // Port 0
  input  logic                          i_cmd0_vld,
  input  stk_pkg::opcode_t              i_cmd0_opcode,
  input  logic [DATA_W-1:0]             i_cmd0_dat,
  output logic                          o_cmd0_ack,
  // Port 1
  input  logic                          i_cmd1_vld,
  input  stk_pkg::opcode_t              i_cmd1_opcode,
  input  logic [DATA_W-1:0]             i_cmd1_dat,
  output logic                          o_cmd1_ack,
  // Port 2
  input  logic                          i_cmd2_vld,
  input  stk_pkg::opcode_t              i_cmd2_opcode,
  input  logic [DATA_W-1:0]             i_cmd2_dat,
  output logic                          o_cmd2_ack,
  // Port 3
  input  logic                          i_cmd3_vld,
  input  stk_pkg::opcode_t              i_cmd3_opcode,
  input  logic [DATA_W-1:0]             i_cmd3_dat,
  output logic                          o_cmd3_ack,
  // Response, one-hot by engine
  output logic [stk_pkg::ENGS_N-1:0]    o_rsp_vld,
  output logic [DATA_W-1:0]             o_rsp_dat,
  output stk_pkg::status_t              o_rsp_status
);

  localparam int ADDR_W = stk_pkg::ENGID_W + $clog2(DEPTH);

  // Ports gathered into arrays for the arbiter
  logic [stk_pkg::ENGS_N-1:0]               cmd_vld;
  stk_pkg::opcode_t [stk_pkg::ENGS_N-1:0]   cmd_opcode;
  logic [stk_pkg::ENGS_N-1:0][DATA_W-1:0]   cmd_dat;
  logic [stk_pkg::ENGS_N-1:0]               cmd_ack;

  // Between the allocation and execute stages
  logic                   busy;
  logic [ADDR_W-1:0]      addr;
  stk_pkg::status_t       status;

  assign cmd_vld    = {i_cmd3_vld, i_cmd2_vld, i_cmd1_vld, i_cmd0_vld};
  assign cmd_opcode = {i_cmd3_opcode, i_cmd2_opcode, i_cmd1_opcode, i_cmd0_opcode};
  assign cmd_dat    = {i_cmd3_dat, i_cmd2_dat, i_cmd1_dat, i_cmd0_dat};

  assign {o_cmd3_ack, o_cmd2_ack, o_cmd1_ack, o_cmd0_ack} = cmd_ack;

  // Admitted command, then the command with its lookup done
  stk_cmd_if #(.DATA_W(DATA_W)) cmd_a ();
  stk_cmd_if #(.DATA_W(DATA_W)) cmd_x ();

  stk_arb #(.DATA_W(DATA_W)) u_arb (
    .clk          (clk),
    .i_reset      (i_reset),
    .i_busy       (busy),
    .i_cmd_vld    (cmd_vld),
    .i_cmd_opcode (cmd_opcode),
    .i_cmd_dat    (cmd_dat),
    .o_cmd_ack    (cmd_ack),
    .cmd          (cmd_a.producer)
  );

  stk_pipe_al #(.DEPTH(DEPTH)) u_pipe_al (
    .clk      (clk),
    .i_reset  (i_reset),
    .o_busy   (busy),
    .cmd_in   (cmd_a.consumer),
    .cmd_out  (cmd_x.producer),
    .o_addr   (addr),
    .o_status (status)
  );

  stk_pipe_ex #(.DATA_W(DATA_W), .DEPTH(DEPTH)) u_pipe_ex (
    .clk          (clk),
    .i_reset      (i_reset),
    .cmd          (cmd_x.consumer),
    .i_addr       (addr),
    .i_status     (status),
    .o_rsp_vld    (o_rsp_vld),
    .o_rsp_dat    (o_rsp_dat),
    .o_rsp_status (o_rsp_status)
  );

endmodule : stk_top

/* rtl/stk_pipe_ex.sv */
module stk_pipe_ex #(
  parameter int DATA_W = 32,
  parameter int DEPTH  = 8
) (
  input  logic                                         clk,
  input  logic                                         i_reset,
  stk_cmd_if.consumer                                  cmd,
  input  logic [stk_pkg::ENGID_W+$clog2(DEPTH)-1:0]    i_addr,
  input  stk_pkg::status_t                             i_status,
  output logic [stk_pkg::ENGS_N-1:0]                   o_rsp_vld,
  output logic [DATA_W-1:0]                            o_rsp_dat,
  output stk_pkg::status_t                             o_rsp_status
);

  // Total words across all engines
  localparam int WORDS_N = stk_pkg::ENGS_N * DEPTH;

  // Shared stack storage, engine regions side by side
  logic [DATA_W-1:0] mem_q [WORDS_N];

  // Combinational read, so a write from the previous cycle is visible
  logic [DATA_W-1:0] rd_dat;
  logic              is_ok;
  logic              mem_we;

  // Response next-state
  logic [stk_pkg::ENGS_N-1:0] rsp_vld_d;
  logic [DATA_W-1:0]          rsp_dat_d;

  assign rd_dat = mem_q[i_addr];
  assign is_ok  = (i_status == stk_pkg::ST_OKAY);

  // Only a successful push writes
  assign mem_we = cmd.vld && (cmd.opcode == stk_pkg::OP_PUSH) && is_ok;

  always_ff @(posedge clk) begin
    if (mem_we) begin
      mem_q[i_addr] <= cmd.dat;
    end
  end

  always_comb begin
    // One-hot engine valid
    rsp_vld_d            = '0;
    rsp_vld_d[cmd.engid] = cmd.vld;
    // Push echoes its word, good pop returns the top, rest is zero
    if (cmd.opcode == stk_pkg::OP_PUSH) begin
      rsp_dat_d = cmd.dat;
    end else if (cmd.opcode == stk_pkg::OP_POP && is_ok) begin
      rsp_dat_d = rd_dat;
    end else begin
      rsp_dat_d = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_rsp_vld <= '0;
    end else begin
      o_rsp_vld <= rsp_vld_d;
    end
  end

  // Data and status held between responses
  always_ff @(posedge clk) begin
    if (cmd.vld) begin
      o_rsp_dat    <= rsp_dat_d;
      o_rsp_status <= i_status;
    end
  end

endmodule : stk_pipe_ex

/* rtl/stk_pipe_al.sv */
module stk_pipe_al #(
  parameter int DEPTH = 8
) (
  input  logic                                             clk,
  input  logic                                             i_reset,
  output logic                                             o_busy,
  stk_cmd_if.consumer                                      cmd_in,
  stk_cmd_if.producer                                      cmd_out,
  output logic [stk_pkg::ENGID_W+$clog2(DEPTH)-1:0]        o_addr,
  output stk_pkg::status_t                                 o_status
);

  // Slot index within one engine
  localparam int SLOT_W = $clog2(DEPTH);
  // Pointer counts 0..DEPTH, one bit wider so full fits
  localparam int PTR_W  = SLOT_W + 1;
  // Storage index, engine in the upper bits
  localparam int ADDR_W = stk_pkg::ENGID_W + SLOT_W;

  // Stack pointer table, one entry per engine, zeroed by the sweep
  logic [PTR_W-1:0] ptr_q [stk_pkg::ENGS_N];

  // Init sweep state
  logic            busy_q;
  stk_pkg::engid_t init_q;

  // Lookup results for the current command
  logic [PTR_W-1:0]  ptr_cur;
  logic [PTR_W-1:0]  ptr_nxt;
  logic [SLOT_W-1:0] slot;
  stk_pkg::status_t  status;
  logic              ptr_we;

  always_comb begin
    ptr_cur = ptr_q[cmd_in.engid];
    ptr_nxt = ptr_cur;
    slot    = ptr_cur[SLOT_W-1:0];
    status  = stk_pkg::ST_OKAY;
    case (cmd_in.opcode)
      stk_pkg::OP_PUSH: begin
        // Push writes the slot at the current pointer
        if (ptr_cur == PTR_W'(DEPTH)) begin
          status = stk_pkg::ST_FULL;
        end else begin
          ptr_nxt = ptr_cur + 1'b1;
        end
      end
      stk_pkg::OP_POP: begin
        // Pop reads the slot just below the pointer
        if (ptr_cur == '0) begin
          status = stk_pkg::ST_EMPTY;
        end else begin
          ptr_nxt = ptr_cur - 1'b1;
          slot    = ptr_nxt[SLOT_W-1:0];
        end
      end
      stk_pkg::OP_CLEAR: ptr_nxt = '0;
      default:           status  = stk_pkg::ST_BADOP;
    endcase
    // Table moves only on a successful command
    ptr_we = cmd_in.vld && (status == stk_pkg::ST_OKAY);
  end

  // Sweep clears one entry per cycle after reset
  always_ff @(posedge clk) begin
    if (i_reset) begin
      busy_q <= 1'b1;
      init_q <= '0;
    end else if (busy_q) begin
      init_q <= init_q + 1'b1;
      if (init_q == stk_pkg::engid_t'(stk_pkg::ENGS_N - 1)) begin
        busy_q <= 1'b0;
      end
    end
  end

  assign o_busy = busy_q;

  // Pointer table write port
  always_ff @(posedge clk) begin
    if (busy_q) begin
      ptr_q[init_q] <= '0;
    end else if (ptr_we) begin
      ptr_q[cmd_in.engid] <= ptr_nxt;
    end
  end

  // Command strobe to the execute stage
  always_ff @(posedge clk) begin
    if (i_reset) begin
      cmd_out.vld <= 1'b0;
    end else begin
      cmd_out.vld <= cmd_in.vld;
    end
  end

  // Payload, status and storage address
  always_ff @(posedge clk) begin
    if (cmd_in.vld) begin
      cmd_out.engid  <= cmd_in.engid;
      cmd_out.opcode <= cmd_in.opcode;
      cmd_out.dat    <= cmd_in.dat;
      o_status       <= status;
      o_addr         <= ADDR_W'({cmd_in.engid, slot});
    end
  end

endmodule : stk_pipe_al

/* rtl/stk_arb.sv */
module stk_arb #(
  parameter int DATA_W = 32
) (
  input  logic                                          clk,
  input  logic                                          i_reset,
  input  logic                                          i_busy,
  input  logic [stk_pkg::ENGS_N-1:0]                    i_cmd_vld,
  input  stk_pkg::opcode_t [stk_pkg::ENGS_N-1:0]        i_cmd_opcode,
  input  logic [stk_pkg::ENGS_N-1:0][DATA_W-1:0]        i_cmd_dat,
  output logic [stk_pkg::ENGS_N-1:0]                    o_cmd_ack,
  stk_cmd_if.producer                                   cmd
);

  // Port granted most recently
  stk_pkg::engid_t last_q;

  // Grant vector, winner index and any-grant flag
  logic [stk_pkg::ENGS_N-1:0] gnt;
  stk_pkg::engid_t            gnt_id;
  logic                       gnt_any;

  // Circular search starting just after the last winner
  always_comb begin
    int idx;
    gnt     = '0;
    gnt_id  = '0;
    gnt_any = 1'b0;
    for (int i = 1; i <= stk_pkg::ENGS_N; i++) begin
      idx = (int'(last_q) + i) % stk_pkg::ENGS_N;
      // First requester wins, nothing while the pointer table is swept
      if (!gnt_any && !i_busy && i_cmd_vld[idx]) begin
        gnt[idx] = 1'b1;
        gnt_id   = stk_pkg::engid_t'(idx);
        gnt_any  = 1'b1;
      end
    end
  end

  // Ack is combinational in the accepting cycle
  assign o_cmd_ack = gnt;

  // Last winner starts at the top port so port 0 is searched first
  always_ff @(posedge clk) begin
    if (i_reset) begin
      last_q  <= stk_pkg::engid_t'(stk_pkg::ENGS_N - 1);
      cmd.vld <= 1'b0;
    end else begin
      cmd.vld <= gnt_any;
      if (gnt_any) begin
        last_q <= gnt_id;
      end
    end
  end

  // Winning command, engine id is the port number
  always_ff @(posedge clk) begin
    if (gnt_any) begin
      cmd.engid  <= gnt_id;
      cmd.opcode <= i_cmd_opcode[gnt_id];
      cmd.dat    <= i_cmd_dat[gnt_id];
    end
  end

endmodule : stk_arb

/* rtl/stk_cmd_if.sv */
interface stk_cmd_if #(
  parameter int DATA_W = 32
) ();

  // Single cycle strobe, one admitted command
  logic             vld;
  // Target engine
  stk_pkg::engid_t  engid;
  // Operation
  stk_pkg::opcode_t opcode;
  // Push data
  logic [DATA_W-1:0] dat;

  // Stage that drives the command
  modport producer (output vld, output engid, output opcode, output dat);

  // Stage that takes the command
  modport consumer (input vld, input engid, input opcode, input dat);

endinterface : stk_cmd_if

/* rtl/stk_pkg.sv */
package stk_pkg;

  // Number of engines, one per command port
  localparam int ENGS_N = 4;

  // Width of an engine index
  localparam int ENGID_W = $clog2(ENGS_N);

  // Engine index, also the number of the requesting port
  typedef logic [ENGID_W-1:0] engid_t;

  // Command codes presented on each port
  typedef enum logic [1:0] {
    // Place a word on top of the stack
    OP_PUSH  = 2'b00,
    // Remove and return the top word
    OP_POP   = 2'b01,
    // Empty the stack
    OP_CLEAR = 2'b10,
    // Not defined, rejected
    OP_RSVD  = 2'b11
  } opcode_t;

  // Response status
  typedef enum logic [1:0] {
    // Command done
    ST_OKAY  = 2'b00,
    // Push to a full stack, nothing stored
    ST_FULL  = 2'b01,
    // Pop from an empty stack, zero data
    ST_EMPTY = 2'b10,
    // Reserved opcode, state unchanged
    ST_BADOP = 2'b11
  } status_t;

endpackage : stk_pkg
